/* rob_commit.sv */
`timescale 1ns/100ps

module rob_commit (
    input  logic                 clk,
    input  logic                 rst_aL,

    // head of the entry store
    input  logic                 head_valid,
    input  rob_pkg::rob_entry_t  head_entry,
    output logic                 head_ready,

    // retirement stream
    output logic                 commit_valid,
    output rob_pkg::rob_reg_t    commit_dest,
    output rob_pkg::rob_data_t   commit_value,
    input  logic                 commit_ready
);
    import rob_pkg::*;

    logic      out_free;
    logic      take_head;
    rob_reg_t  dest_r;
    rob_data_t value_r;
    logic      valid_r;

    // slot is free when empty or being emptied on this edge
    assign out_free = !valid_r || commit_ready;

    // head only leaves once its result is in
    assign take_head  = head_valid && head_entry.done && out_free;
    assign head_ready = take_head;

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            valid_r <= 1'b0;
        end else begin
            if (take_head) begin
                valid_r <= 1'b1;
            end else if (commit_ready) begin
                valid_r <= 1'b0;
            end
        end
    end

    // output payload, loaded only on accept so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (take_head) begin
            dest_r  <= head_entry.dest;
            value_r <= head_entry.value;
        end
    end

    assign commit_valid = valid_r;
    assign commit_dest  = dest_r;
    assign commit_value = value_r;

endmodule

/* rob_entry_store.sv */
`timescale 1ns/100ps

module rob_entry_store (
    input  logic                                           clk,
    input  logic                                           rst_aL,

    // allocation side
    input  logic                                           enq_valid,
    input  rob_pkg::rob_entry_t                            enq_entry,
    output logic                                           enq_ready,
    output rob_pkg::rob_tag_t                              enq_tag,

    // retire side
    output logic                                           head_valid,
    output rob_pkg::rob_entry_t                            head_entry,
    input  logic                                           head_ready,

    // random access
    input  rob_pkg::rob_tag_t   [rob_pkg::N_RD_PORTS-1:0]  rd_addr,
    output rob_pkg::rob_entry_t [rob_pkg::N_RD_PORTS-1:0]  rd_data,
    input  logic                [rob_pkg::N_WB_PORTS-1:0]  wr_en,
    input  rob_pkg::rob_tag_t   [rob_pkg::N_WB_PORTS-1:0]  wr_addr,
    input  rob_pkg::rob_entry_t [rob_pkg::N_WB_PORTS-1:0]  wr_data
);
    import rob_pkg::*;

    rob_ctr_t enq_ctr_r;
    rob_ctr_t deq_ctr_r;
    rob_entry_t [ROB_DEPTH-1:0] entries_r;

    rob_tag_t enq_ptr;
    rob_tag_t deq_ptr;
    rob_ctr_t in_use;
    logic     is_empty;
    logic     is_full;
    logic     enq_fire;
    logic     deq_fire;

    assign enq_ptr = enq_ctr_r[TAG_WIDTH-1:0];
    assign deq_ptr = deq_ctr_r[TAG_WIDTH-1:0];

    // occupancy wraps cleanly thanks to the extra counter bit
    assign in_use   = enq_ctr_r - deq_ctr_r;
    assign is_empty = (enq_ctr_r == deq_ctr_r);
    assign is_full  = (in_use == rob_ctr_t'(ROB_DEPTH));

    assign enq_ready = !is_full;
    assign enq_tag   = enq_ptr;
    assign enq_fire  = enq_valid && enq_ready;

    assign head_valid = !is_empty;
    assign head_entry = entries_r[deq_ptr];
    assign deq_fire   = head_valid && head_ready;

    // combinational lookups
    always_comb begin
        for (int i = 0; i < N_RD_PORTS; i++) begin
            rd_data[i] = entries_r[rd_addr[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            enq_ctr_r <= '0;
            deq_ctr_r <= '0;
        end else begin
            if (enq_fire) begin
                enq_ctr_r <= enq_ctr_r + rob_ctr_t'(1);
            end
            if (deq_fire) begin
                deq_ctr_r <= deq_ctr_r + rob_ctr_t'(1);
            end
        end
    end

    // allocation first, writeback writes after it so they win on a clash
    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            entries_r <= '0;
        end else begin
            if (enq_fire) begin
                entries_r[enq_ptr] <= enq_entry;
            end
            for (int i = 0; i < N_WB_PORTS; i++) begin
                if (wr_en[i]) begin
                    entries_r[wr_addr[i]] <= wr_data[i];
                end
            end
        end
    end

endmodule

/* rob_operand_read.sv */
`timescale 1ns/100ps

module rob_operand_read (
    // lookup requests
    input  rob_pkg::rob_tag_t   [rob_pkg::N_OPND_PORTS-1:0]  opnd_tag,
    output logic                [rob_pkg::N_OPND_PORTS-1:0]  opnd_done,
    output rob_pkg::rob_data_t  [rob_pkg::N_OPND_PORTS-1:0]  opnd_value,

    // store read ports
    output rob_pkg::rob_tag_t   [rob_pkg::N_OPND_PORTS-1:0]  rd_addr,
    input  rob_pkg::rob_entry_t [rob_pkg::N_OPND_PORTS-1:0]  rd_data,

    // results landing this cycle
    input  logic                [rob_pkg::N_WB_PORTS-1:0]    wb_valid,
    input  rob_pkg::rob_tag_t   [rob_pkg::N_WB_PORTS-1:0]    wb_tag,
    input  rob_pkg::rob_data_t  [rob_pkg::N_WB_PORTS-1:0]    wb_value
);
    import rob_pkg::*;

    always_comb begin
        for (int i = 0; i < N_OPND_PORTS; i++) begin
            rd_addr[i] = opnd_tag[i];
        end
    end

    // stored value unless a writeback to the same tag is in flight
    always_comb begin
        for (int i = 0; i < N_OPND_PORTS; i++) begin
            opnd_done[i]  = rd_data[i].done;
            opnd_value[i] = rd_data[i].value;
            // wb ports never share a tag, so at most one of these hits
            for (int j = 0; j < N_WB_PORTS; j++) begin
                if (wb_valid[j] && (wb_tag[j] == opnd_tag[i])) begin
                    opnd_done[i]  = 1'b1;
                    opnd_value[i] = wb_value[j];
                end
            end
        end
    end

endmodule

/* rob_pkg.sv */
package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 8;
    localparam int TAG_WIDTH = 3;
    // counters carry one extra bit to tell full from empty
    localparam int CTR_WIDTH = TAG_WIDTH + 1;

    // payload widths
    localparam int DATA_WIDTH = 32;
    localparam int REG_WIDTH = 5;

    // port counts
    localparam int N_WB_PORTS = 2;
    localparam int N_OPND_PORTS = 2;
    // writeback merge reads the entry it updates, so it needs its own read ports
    localparam int N_RD_PORTS = N_OPND_PORTS + N_WB_PORTS;

    // entry tag, also the store index
    typedef logic [TAG_WIDTH-1:0] rob_tag_t;

    // result value
    typedef logic [DATA_WIDTH-1:0] rob_data_t;

    // architectural destination register
    typedef logic [REG_WIDTH-1:0] rob_reg_t;

    // allocation and retire counter
    typedef logic [CTR_WIDTH-1:0] rob_ctr_t;

    // one stored entry, 38 bits
    typedef struct packed {
        rob_reg_t  dest;
        logic      done;
        rob_data_t value;
    } rob_entry_t;

endpackage

/* rob_properties.sv */
`timescale 1ns/100ps

module rob_properties (
    input logic                                            clk,
    input logic                                            rst_aL,
    input logic                                            disp_valid,
    input logic                                            disp_ready,
    input logic                                            head_valid,
    input logic                                            head_ready,
    input logic               [rob_pkg::N_WB_PORTS-1:0]    wb_valid,
    input rob_pkg::rob_tag_t  [rob_pkg::N_WB_PORTS-1:0]    wb_tag,
    input logic                                            commit_valid,
    input rob_pkg::rob_reg_t                               commit_dest,
    input rob_pkg::rob_data_t                              commit_value,
    input logic                                            commit_ready
);
    import rob_pkg::*;

    rob_ctr_t occupancy;

    // entries held in the store
    always_ff @(posedge clk or negedge rst_aL) begin
        if (!rst_aL) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + rob_ctr_t'(disp_valid && disp_ready)
                         - rob_ctr_t'(head_valid && head_ready);
        end
    end

    wb_tags_differ: assert property (@(posedge clk) disable iff (!rst_aL)
        (wb_valid[0] && wb_valid[1]) |-> (wb_tag[0] != wb_tag[1]))
        else $error("both writeback ports carry the same tag");

    commit_holds: assert property (@(posedge clk) disable iff (!rst_aL)
        (commit_valid && !commit_ready) |=>
        (commit_valid && $stable(commit_dest) && $stable(commit_value)))
        else $error("commit outputs changed while stalled");

    stall_only_when_full: assert property (@(posedge clk) disable iff (!rst_aL)
        !disp_ready |-> (occupancy == rob_ctr_t'(ROB_DEPTH)))
        else $error("dispatch stalled with free entries");

endmodule

/* rob_tb.sv */
`timescale 1ns/100ps

module rob_tb;
    import rob_pkg::*;

    localparam int TOTAL_DISP = 400;
    // ten cycles per dispatch covers the stalls
    localparam int MAX_CYCLES = TOTAL_DISP * 10;

    logic                          clk;
    logic                          rst_aL;
    logic                          disp_valid;
    rob_reg_t                      disp_dest;
    logic                          disp_ready;
    rob_tag_t                      alloc_tag;
    logic      [N_WB_PORTS-1:0]    wb_valid;
    rob_tag_t  [N_WB_PORTS-1:0]    wb_tag;
    rob_data_t [N_WB_PORTS-1:0]    wb_value;
    rob_tag_t  [N_OPND_PORTS-1:0]  opnd_tag;
    logic      [N_OPND_PORTS-1:0]  opnd_done;
    rob_data_t [N_OPND_PORTS-1:0]  opnd_value;
    logic                          commit_valid;
    rob_reg_t                      commit_dest;
    rob_data_t                     commit_value;
    logic                          commit_ready;

    // in-flight entries, oldest first
    rob_tag_t  q_tag[$];
    rob_reg_t  q_dest[$];
    logic      q_done[$];
    rob_data_t q_value[$];
    // the oldest entry sits in the output register
    logic      out_full = 1'b0;
    rob_tag_t  next_tag = '0;
    int        n_disp = 0;
    int        n_commit = 0;
    int        cycles = 0;

    tb_clock_gen u_clk (.clk(clk));

    rob_top UUT (.*);

    bind rob_top rob_properties u_properties (
        .clk          (clk),
        .rst_aL       (rst_aL),
        .disp_valid   (disp_valid),
        .disp_ready   (disp_ready),
        .head_valid   (head_valid),
        .head_ready   (head_ready),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_value (commit_value),
        .commit_ready (commit_ready)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_commit(input rob_reg_t got_dest, input rob_data_t got_value,
                                input rob_reg_t exp_dest, input rob_data_t exp_value);
        if (got_dest !== exp_dest) begin
            $display("** Error: commit_dest = 0x%h, expected 0x%h", got_dest, exp_dest);
            abort_run();
        end else if (got_value !== exp_value) begin
            $display("** Error: commit_value = 0x%h, expected 0x%h", got_value, exp_value);
            abort_run();
        end
    endtask

    task automatic check_operand(input int port, input logic got_done, input rob_data_t got_value,
                                 input logic exp_done, input rob_data_t exp_value);
        if (got_done !== exp_done) begin
            $display("** Error: opnd_done[%0d] = 0x%h, expected 0x%h", port, got_done, exp_done);
            abort_run();
        end else if (got_value !== exp_value) begin
            $display("** Error: opnd_value[%0d] = 0x%h, expected 0x%h",
                     port, got_value, exp_value);
            abort_run();
        end
    endtask

    task automatic check_tag(input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            $display("** Error: alloc_tag = 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // a tag may appear twice when the older copy waits in the output register
    function automatic int youngest_with_tag(rob_tag_t tag);
        int idx;
        idx = -1;
        for (int k = 0; k < q_tag.size(); k++) begin
            if (q_tag[k] == tag) begin
                idx = k;
            end
        end
        return idx;
    endfunction

    // expected {done, value}, a result landing this cycle wins
    function automatic logic [DATA_WIDTH:0] expect_operand(rob_tag_t tag);
        int idx;
        logic [DATA_WIDTH:0] result;
        idx = youngest_with_tag(tag);
        result = {q_done[idx], q_value[idx]};
        for (int j = 0; j < N_WB_PORTS; j++) begin
            if (wb_valid[j] && (wb_tag[j] == tag)) begin
                result = {1'b1, wb_value[j]};
            end
        end
        return result;
    endfunction

    always @(posedge clk) begin : compare_outputs
        logic [DATA_WIDTH:0] exp_opnd;
        int idx;
        int head_idx;
        logic take;
        if (rst_aL) begin
            for (int i = 0; i < N_OPND_PORTS; i++) begin
                if (youngest_with_tag(opnd_tag[i]) >= 0) begin
                    exp_opnd = expect_operand(opnd_tag[i]);
                    check_operand(i, opnd_done[i], opnd_value[i],
                                  exp_opnd[DATA_WIDTH], exp_opnd[DATA_WIDTH-1:0]);
                end
            end
            check_flag("commit_valid", commit_valid, out_full);
            // store count leaves out the entry held in the output register
            check_flag("disp_ready", disp_ready,
                       (q_tag.size() - int'(out_full)) < ROB_DEPTH);
            // store head moves out once done and the output slot frees up
            head_idx = int'(out_full);
            take = (!out_full || commit_ready) && (q_tag.size() > head_idx)
                   && q_done[head_idx];
            if (commit_valid && commit_ready) begin
                if (q_tag.size() == 0) begin
                    $display("A commit came out while no entry was in flight");
                    abort_run();
                end else if (!q_done[0]) begin
                    $display("Tag %0d was committed before its result arrived", q_tag[0]);
                    abort_run();
                end else begin
                    check_commit(commit_dest, commit_value, q_dest[0], q_value[0]);
                    void'(q_tag.pop_front());
                    void'(q_dest.pop_front());
                    void'(q_done.pop_front());
                    void'(q_value.pop_front());
                    n_commit++;
                end
            end
            if (take) begin
                out_full = 1'b1;
            end else if (commit_ready) begin
                out_full = 1'b0;
            end
            for (int j = 0; j < N_WB_PORTS; j++) begin
                idx = youngest_with_tag(wb_tag[j]);
                if (wb_valid[j] && (idx >= 0)) begin
                    q_done[idx]  = 1'b1;
                    q_value[idx] = wb_value[j];
                end
            end
            if (disp_valid && disp_ready) begin
                check_tag(alloc_tag, next_tag);
                q_tag.push_back(next_tag);
                q_dest.push_back(disp_dest);
                q_done.push_back(1'b0);
                q_value.push_back('0);
                next_tag++;
                n_disp++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            abort_run();
        end
    end

    // one cycle of stimulus, percentages for dispatch, writeback and commit_ready
    task automatic drive_cycle(input int p_disp, input int p_wb, input int p_ready);
        int pick;
        int open_idx[$];
        @(negedge clk);
        disp_valid = (n_disp < TOTAL_DISP) && (int'($urandom % 100) < p_disp);
        disp_dest  = rob_reg_t'($urandom);
        for (int k = 0; k < q_tag.size(); k++) begin
            if (!q_done[k]) begin
                open_idx.push_back(k);
            end
        end
        // random not-done targets, never the same one on both ports
        for (int j = 0; j < N_WB_PORTS; j++) begin
            wb_valid[j] = 1'b0;
            wb_value[j] = $urandom;
            if ((open_idx.size() > 0) && (int'($urandom % 100) < p_wb)) begin
                pick = int'($urandom % open_idx.size());
                wb_valid[j] = 1'b1;
                wb_tag[j]   = q_tag[open_idx[pick]];
                open_idx.delete(pick);
            end
        end
        for (int i = 0; i < N_OPND_PORTS; i++) begin
            pick = int'($urandom % N_WB_PORTS);
            if (wb_valid[pick] && ($urandom % 3 == 0)) begin
                opnd_tag[i] = wb_tag[pick];
            end else if (q_tag.size() > 0) begin
                opnd_tag[i] = q_tag[$urandom % q_tag.size()];
            end else begin
                opnd_tag[i] = rob_tag_t'($urandom);
            end
        end
        commit_ready = int'($urandom % 100) < p_ready;
    endtask

    initial begin
        void'($urandom(33));
        rst_aL       = 1'b0;
        disp_valid   = 1'b0;
        disp_dest    = '0;
        wb_valid     = '0;
        wb_tag       = '0;
        wb_value     = '0;
        opnd_tag     = '0;
        commit_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_aL = 1'b1;
        check_flag("disp_ready", disp_ready, 1'b1);
        check_flag("commit_valid", commit_valid, 1'b0);

        // fill past capacity with commit held off
        repeat (12) drive_cycle(100, 0, 0);
        // results arrive out of order behind a stalled output
        repeat (6) drive_cycle(0, 100, 0);
        while (n_disp < TOTAL_DISP) begin
            drive_cycle(70, 60, 60);
        end
        while (q_tag.size() > 0) begin
            drive_cycle(0, 80, 70);
        end
        drive_cycle(0, 0, 100);

        if ((n_commit == TOTAL_DISP) && !commit_valid) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Only %0d of %0d entries were committed", n_commit, TOTAL_DISP);
            abort_run();
        end
    end

endmodule

/* rob_top.sv */
`timescale 1ns/100ps

module rob_top (
    input  logic                                            clk,
    input  logic                                            rst_aL,

    // dispatch
    input  logic                                            disp_valid,
    input  rob_pkg::rob_reg_t                               disp_dest,
    output logic                                            disp_ready,
    output rob_pkg::rob_tag_t                               alloc_tag,

    // writeback
    input  logic               [rob_pkg::N_WB_PORTS-1:0]    wb_valid,
    input  rob_pkg::rob_tag_t  [rob_pkg::N_WB_PORTS-1:0]    wb_tag,
    input  rob_pkg::rob_data_t [rob_pkg::N_WB_PORTS-1:0]    wb_value,

    // operand lookup
    input  rob_pkg::rob_tag_t  [rob_pkg::N_OPND_PORTS-1:0]  opnd_tag,
    output logic               [rob_pkg::N_OPND_PORTS-1:0]  opnd_done,
    output rob_pkg::rob_data_t [rob_pkg::N_OPND_PORTS-1:0]  opnd_value,

    // commit
    output logic                                            commit_valid,
    output rob_pkg::rob_reg_t                               commit_dest,
    output rob_pkg::rob_data_t                              commit_value,
    input  logic                                            commit_ready
);
    import rob_pkg::*;

    rob_entry_t disp_entry;

    logic       head_valid;
    rob_entry_t head_entry;
    logic       head_ready;

    // full set of store read ports
    rob_tag_t   [N_RD_PORTS-1:0] rd_addr;
    rob_entry_t [N_RD_PORTS-1:0] rd_data;

    // operand share of the read ports
    rob_tag_t   [N_OPND_PORTS-1:0] opnd_rd_addr;
    rob_entry_t [N_OPND_PORTS-1:0] opnd_rd_data;

    // writeback share of the read ports
    rob_tag_t   [N_WB_PORTS-1:0] wb_rd_addr;
    rob_entry_t [N_WB_PORTS-1:0] wb_rd_data;

    logic       [N_WB_PORTS-1:0] wr_en;
    rob_tag_t   [N_WB_PORTS-1:0] wr_addr;
    rob_entry_t [N_WB_PORTS-1:0] wr_data;

    // new entries start not done with a zero result
    assign disp_entry.dest  = disp_dest;
    assign disp_entry.done  = 1'b0;
    assign disp_entry.value = '0;

    // operand ports low, writeback ports high
    assign rd_addr      = {wb_rd_addr, opnd_rd_addr};
    assign opnd_rd_data = rd_data[N_OPND_PORTS-1:0];
    assign wb_rd_data   = rd_data[N_RD_PORTS-1:N_OPND_PORTS];

    rob_entry_store u_store (
        .clk        (clk),
        .rst_aL     (rst_aL),
        .enq_valid  (disp_valid),
        .enq_entry  (disp_entry),
        .enq_ready  (disp_ready),
        .enq_tag    (alloc_tag),
        .head_valid (head_valid),
        .head_entry (head_entry),
        .head_ready (head_ready),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    rob_writeback u_writeback (
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_value (wb_value),
        .rd_addr  (wb_rd_addr),
        .rd_data  (wb_rd_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    rob_operand_read u_operand_read (
        .opnd_tag   (opnd_tag),
        .opnd_done  (opnd_done),
        .opnd_value (opnd_value),
        .rd_addr    (opnd_rd_addr),
        .rd_data    (opnd_rd_data),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .wb_value   (wb_value)
    );

    rob_commit u_commit (
        .clk          (clk),
        .rst_aL       (rst_aL),
        .head_valid   (head_valid),
        .head_entry   (head_entry),
        .head_ready   (head_ready),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_value (commit_value),
        .commit_ready (commit_ready)
    );

endmodule

/* rob_writeback.sv */
`timescale 1ns/100ps

module rob_writeback (
    // from the execution units
    input  logic                [rob_pkg::N_WB_PORTS-1:0]  wb_valid,
    input  rob_pkg::rob_tag_t   [rob_pkg::N_WB_PORTS-1:0]  wb_tag,
    input  rob_pkg::rob_data_t  [rob_pkg::N_WB_PORTS-1:0]  wb_value,

    // read of the entry being updated
    output rob_pkg::rob_tag_t   [rob_pkg::N_WB_PORTS-1:0]  rd_addr,
    input  rob_pkg::rob_entry_t [rob_pkg::N_WB_PORTS-1:0]  rd_data,

    // write back into the store
    output logic                [rob_pkg::N_WB_PORTS-1:0]  wr_en,
    output rob_pkg::rob_tag_t   [rob_pkg::N_WB_PORTS-1:0]  wr_addr,
    output rob_pkg::rob_entry_t [rob_pkg::N_WB_PORTS-1:0]  wr_data
);
    import rob_pkg::*;

    rob_entry_t [N_WB_PORTS-1:0] merged;

    // read-modify-write of each target entry
    always_comb begin
        for (int i = 0; i < N_WB_PORTS; i++) begin
            rd_addr[i] = wb_tag[i];

            // dest was set at dispatch and is kept as is
            merged[i].dest  = rd_data[i].dest;
            merged[i].done  = 1'b1;
            merged[i].value = wb_value[i];

            wr_en[i]   = wb_valid[i];
            wr_addr[i] = wb_tag[i];
            wr_data[i] = merged[i];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module rob_tb -o rob_sim

# the simulator may exit nonzero, the log decides
./obj_dir/rob_sim 2>&1 | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* tb.f */
rob_pkg.sv
rob_entry_store.sv
rob_writeback.sv
rob_operand_read.sv
rob_commit.sv
rob_top.sv
tb_clock_gen.sv
rob_properties.sv
rob_tb.sv

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule
